// ==== design/receive_pkg.sv ====
// shared widths and types for the capture path
// samples, input words, configuration, discriminator output, readout stream
`default_nettype none

package receive_pkg;

  // default widths, the top level parameters must match these
  localparam int SAMPLE_WIDTH_MAX = 16;
  localparam int PARALLEL_SAMPLES_MAX = 2;
  localparam int CHANNELS_MAX = 2;
  localparam int INDEX_WIDTH = 32;
  localparam int CHANNEL_BITS = (CHANNELS_MAX > 1) ? $clog2(CHANNELS_MAX) : 1;

  typedef logic signed [SAMPLE_WIDTH_MAX-1:0] sample_t;
  typedef sample_t [PARALLEL_SAMPLES_MAX-1:0] adc_word_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////
  typedef struct packed {
    sample_t threshold_high;
    sample_t threshold_low;
    logic    differentiate;
  } channel_config_t;

  typedef channel_config_t [CHANNELS_MAX-1:0] receive_config_t;

  //////////////////////////////////////////////////
  // datapath words
  //////////////////////////////////////////////////
  typedef struct packed {
    logic      save;
    logic      run_start;
    index_t    index;
    adc_word_t data;
  } disc_word_t;

  // payload is an index for timestamps, otherwise an adc_word_t
  typedef struct packed {
    logic                    is_timestamp;
    logic [CHANNEL_BITS-1:0] channel;
    logic [INDEX_WIDTH-1:0]  payload;
  } readout_word_t;

endpackage

`default_nettype wire

// ==== design/sample_fifo.sv ====
// first-word-fall-through FIFO on a register array, entry type set by parameter
`default_nettype none

module sample_fifo #(
  parameter type entry_t = logic [31:0],
  parameter int DEPTH = 16
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   clear,
  input  logic   write,
  input  logic   read,
  input  entry_t write_data,
  output entry_t read_data,
  output logic   full,
  output logic   empty
);

  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t mem [DEPTH];
  logic [ADDR_WIDTH-1:0] write_ptr;
  logic [ADDR_WIDTH-1:0] read_ptr;
  logic [ADDR_WIDTH:0] count;
  logic do_write;
  logic do_read;

  assign do_write = write & ~full;
  assign do_read = read & ~empty;
  assign full = (count == (ADDR_WIDTH + 1)'(DEPTH));
  assign empty = (count == '0);
  // head of the queue is always visible
  assign read_data = mem[read_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[write_ptr] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      write_ptr <= '0;
      read_ptr <= '0;
      count <= '0;
    end else begin
      if (do_write) begin
        write_ptr <= (write_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
      end
      if (do_read) begin
        read_ptr <= (read_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/sample_conditioner.sv ====
// per-channel conditioner with a registered raw/differentiated select
`default_nettype none

module sample_conditioner #(
  parameter int PARALLEL_SAMPLES = 2,
  parameter int SAMPLE_WIDTH = 16
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   config_load,
  input  logic                   differentiate,
  input  receive_pkg::adc_word_t in_word,
  input  logic                   in_valid,
  output receive_pkg::adc_word_t out_word,
  output logic                   out_valid
);
  import receive_pkg::*;

  logic differentiate_sel;
  // last sample of the previous valid word
  sample_t prev_sample;
  adc_word_t diff_word;
  // one extra bit so the difference cannot overflow
  logic signed [SAMPLE_WIDTH:0] diff [PARALLEL_SAMPLES];

  //////////////////////////////////////////////////
  // differentiator
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      if (i == 0) begin
        diff[i] = $signed(in_word[0]) - $signed(prev_sample);
      end else begin
        diff[i] = $signed(in_word[i]) - $signed(in_word[i-1]);
      end
      // dropping the lsb is an arithmetic shift, so it rounds toward minus infinity
      diff_word[i] = diff[i][SAMPLE_WIDTH:1];
    end
  end

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      differentiate_sel <= 1'b0;
      prev_sample <= '0;
      out_valid <= 1'b0;
    end else begin
      if (config_load) begin
        differentiate_sel <= differentiate;
      end
      if (in_valid) begin
        prev_sample <= in_word[PARALLEL_SAMPLES-1];
      end
      out_valid <= in_valid;
    end
  end

  // output word, one cycle after the input
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_word <= differentiate_sel ? diff_word : in_word;
    end
  end

endmodule

`default_nettype wire

// ==== design/sample_discriminator.sv ====
// per-channel hysteresis discriminator
// also counts words since capture start and flags the start of each saved run
`default_nettype none

module sample_discriminator #(
  parameter int PARALLEL_SAMPLES = 2,
  parameter int SAMPLE_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         config_load,
  input  receive_pkg::channel_config_t thresholds,
  input  logic                         capture_start,
  input  receive_pkg::adc_word_t       in_word,
  input  logic                         in_valid,
  output receive_pkg::disc_word_t      out,
  output logic                         out_valid
);
  import receive_pkg::*;

  logic signed [SAMPLE_WIDTH-1:0] threshold_high_q;
  logic signed [SAMPLE_WIDTH-1:0] threshold_low_q;
  logic any_above;
  logic all_below;
  // hysteresis flag, also tells whether the previous word was saved
  logic active;
  logic active_next;
  index_t index;

  //////////////////////////////////////////////////
  // threshold compare
  //////////////////////////////////////////////////
  always_comb begin
    any_above = 1'b0;
    all_below = 1'b1;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      if ($signed(in_word[i]) > threshold_high_q) begin
        any_above = 1'b1;
      end
      if (!($signed(in_word[i]) < threshold_low_q)) begin
        all_below = 1'b0;
      end
    end
    if (any_above) begin
      active_next = 1'b1;
    end else if (all_below) begin
      active_next = 1'b0;
    end else begin
      active_next = active;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      threshold_high_q <= '0;
      threshold_low_q <= '0;
      active <= 1'b0;
      index <= '0;
      out_valid <= 1'b0;
    end else begin
      if (config_load) begin
        threshold_high_q <= thresholds.threshold_high;
        threshold_low_q <= thresholds.threshold_low;
      end
      if (capture_start) begin
        // the word in this stage belongs to the previous capture
        active <= 1'b0;
        index <= '0;
        out_valid <= 1'b0;
      end else begin
        out_valid <= in_valid;
        if (in_valid) begin
          active <= active_next;
          index <= index + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out.save <= active_next;
      out.run_start <= active_next & ~active;
      out.index <= index;
      out.data <= in_word;
    end
  end

endmodule

`default_nettype wire

// ==== design/sparse_buffer.sv ====
// per-channel timestamp and sample FIFOs with overflow cut-off
// capture state machine and readout sequencer with a valid/ready output
`default_nettype none

module sparse_buffer #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   capture_start,
  input  logic                                   capture_stop,
  input  receive_pkg::disc_word_t [CHANNELS-1:0] in,
  input  logic [CHANNELS-1:0]                    in_valid,
  output logic                                   capturing,
  output receive_pkg::readout_word_t             out_word,
  output logic                                   out_valid,
  output logic                                   out_last,
  input  logic                                   out_ready
);
  import receive_pkg::*;

  // readout sources in order: ch0 timestamps, ch0 samples, ch1 timestamps, ...
  localparam int SOURCES = 2 * CHANNELS;
  localparam int PTR_WIDTH = $clog2(SOURCES + 1);

  typedef enum logic [1:0] {state_idle, state_capture, state_readout} state_t;

  state_t state;
  logic [1:0] stop_delay;
  logic start_now;
  logic [CHANNELS-1:0] ts_write, samp_write, ts_read, samp_read;
  logic [CHANNELS-1:0] ts_full, samp_full, ts_empty, samp_empty;
  index_t ts_data [CHANNELS];
  adc_word_t samp_data [CHANNELS];
  logic [SOURCES-1:0] src_empty;
  logic [PTR_WIDTH-1:0] src_ptr;
  logic ptr_empty, remaining, src_pop, out_load, terminator;
  logic stage_valid;
  readout_word_t stage_word, next_word;

  assign capturing = (state == state_capture);
  assign start_now = (state == state_idle) & capture_start;

  //////////////////////////////////////////////////
  // per-channel storage
  //////////////////////////////////////////////////
  for (genvar c = 0; c < CHANNELS; c++) begin : g_channel
    logic cut;
    logic wants;
    logic blocked;

    assign wants = capturing & in_valid[c] & in[c].save & ~cut;
    assign blocked = samp_full[c] | (in[c].run_start & ts_full[c]);
    assign samp_write[c] = wants & ~blocked;
    assign ts_write[c] = samp_write[c] & in[c].run_start;
    assign ts_read[c] = src_pop & (src_ptr == PTR_WIDTH'(2 * c));
    assign samp_read[c] = src_pop & (src_ptr == PTR_WIDTH'(2 * c + 1));
    assign src_empty[2*c] = ts_empty[c];
    assign src_empty[2*c+1] = samp_empty[c];

    // once a FIFO fills, the channel saves nothing more this capture
    always_ff @(posedge clk) begin
      if (reset || start_now) begin
        cut <= 1'b0;
      end else if (wants && blocked) begin
        cut <= 1'b1;
      end
    end

    sample_fifo #(.entry_t(index_t), .DEPTH(DEPTH)) ts_fifo (
      .clk, .reset, .clear(start_now),
      .write(ts_write[c]), .read(ts_read[c]),
      .write_data(in[c].index), .read_data(ts_data[c]),
      .full(ts_full[c]), .empty(ts_empty[c])
    );

    sample_fifo #(.entry_t(adc_word_t), .DEPTH(DEPTH)) samp_fifo (
      .clk, .reset, .clear(start_now),
      .write(samp_write[c]), .read(samp_read[c]),
      .write_data(in[c].data), .read_data(samp_data[c]),
      .full(samp_full[c]), .empty(samp_empty[c])
    );
  end

  //////////////////////////////////////////////////
  // readout sequencer
  //////////////////////////////////////////////////
  always_comb begin
    remaining = 1'b0;
    ptr_empty = 1'b1;
    next_word = '0;
    for (int k = 0; k < SOURCES; k++) begin
      if (k >= src_ptr && !src_empty[k]) begin
        remaining = 1'b1;
      end
      if (k == src_ptr) begin
        ptr_empty = src_empty[k];
      end
    end
    for (int c = 0; c < CHANNELS; c++) begin
      if (src_ptr == PTR_WIDTH'(2 * c)) begin
        next_word = '{is_timestamp: 1'b1, channel: CHANNEL_BITS'(c), payload: ts_data[c]};
      end else if (src_ptr == PTR_WIDTH'(2 * c + 1)) begin
        next_word = '{is_timestamp: 1'b0, channel: CHANNEL_BITS'(c), payload: samp_data[c]};
      end
    end
    out_load = (state == state_readout) & stage_valid & (~out_valid | out_ready);
    src_pop = (state == state_readout) & (~stage_valid | out_load) & ~ptr_empty;
    // empty capture, send a lone terminator
    terminator = (state == state_readout) & ~stage_valid & ~remaining & ~out_valid;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
      stop_delay <= '0;
      src_ptr <= '0;
      stage_valid <= 1'b0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else begin
      case (state)
        state_idle: begin
          if (capture_start) begin
            state <= state_capture;
            stop_delay <= '0;
          end
        end
        state_capture: begin
          // two extra cycles let words already in the pipeline land
          if (stop_delay[1]) begin
            state <= state_readout;
            stop_delay <= '0;
            src_ptr <= '0;
          end else if (stop_delay[0]) begin
            stop_delay <= 2'b10;
          end else if (capture_stop) begin
            stop_delay <= 2'b01;
          end
        end
        state_readout: begin
          if (src_pop) begin
            stage_valid <= 1'b1;
          end else if (out_load) begin
            stage_valid <= 1'b0;
          end
          if (!src_pop && ptr_empty && src_ptr < PTR_WIDTH'(SOURCES)) begin
            src_ptr <= src_ptr + 1'b1;
          end
          if (out_load || terminator) begin
            out_valid <= 1'b1;
            out_last <= terminator | ~remaining;
          end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
          end
          if (out_valid && out_ready && out_last) begin
            state <= state_idle;
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (src_pop) begin
      stage_word <= next_word;
    end
    if (terminator) begin
      out_word <= '{is_timestamp: 1'b1, channel: CHANNEL_BITS'(CHANNELS - 1), payload: '0};
    end else if (out_load) begin
      out_word <= stage_word;
    end
  end

endmodule

`default_nettype wire

// ==== design/receive_top.sv ====
// top level of the capture path
// conditioner and discriminator per channel, one shared sparse buffer
`default_nettype none

module receive_top #(
  parameter int CHANNELS = 2,
  parameter int PARALLEL_SAMPLES = 2,
  parameter int SAMPLE_WIDTH = 16,
  parameter int BUFFER_DEPTH = 16
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  receive_pkg::adc_word_t [CHANNELS-1:0] adc_data,
  input  logic [CHANNELS-1:0]                   adc_valid,
  input  receive_pkg::receive_config_t          config_data,
  input  logic                                  config_load,
  input  logic                                  capture_start,
  input  logic                                  capture_stop,
  output receive_pkg::readout_word_t            out_word,
  output logic                                  out_valid,
  output logic                                  out_last,
  input  logic                                  out_ready
);
  import receive_pkg::*;

  adc_word_t [CHANNELS-1:0] conditioner_word;
  logic [CHANNELS-1:0] conditioner_valid;
  disc_word_t [CHANNELS-1:0] disc_out;
  logic [CHANNELS-1:0] disc_valid;
  logic capturing;
  logic config_accept;
  logic start_accept;

  // the packed types are sized by the package
  if (SAMPLE_WIDTH != SAMPLE_WIDTH_MAX || PARALLEL_SAMPLES != PARALLEL_SAMPLES_MAX ||
      CHANNELS != CHANNELS_MAX) begin : g_width_check
    $error("receive_top parameters do not match receive_pkg widths");
  end

  // config and restarts only take effect outside a capture
  assign config_accept = config_load & ~capturing;
  assign start_accept = capture_start & ~capturing;

  //////////////////////////////////////////////////
  // per-channel front end
  //////////////////////////////////////////////////
  for (genvar c = 0; c < CHANNELS; c++) begin : g_channel
    sample_conditioner #(
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
      .SAMPLE_WIDTH(SAMPLE_WIDTH)
    ) conditioner (
      .clk, .reset,
      .config_load(config_accept),
      .differentiate(config_data[c].differentiate),
      .in_word(adc_data[c]), .in_valid(adc_valid[c]),
      .out_word(conditioner_word[c]), .out_valid(conditioner_valid[c])
    );

    sample_discriminator #(
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
      .SAMPLE_WIDTH(SAMPLE_WIDTH)
    ) discriminator (
      .clk, .reset,
      .config_load(config_accept), .thresholds(config_data[c]),
      .capture_start(start_accept),
      .in_word(conditioner_word[c]), .in_valid(conditioner_valid[c]),
      .out(disc_out[c]), .out_valid(disc_valid[c])
    );
  end

  sparse_buffer #(.CHANNELS(CHANNELS), .DEPTH(BUFFER_DEPTH)) buffer (
    .clk, .reset,
    .capture_start, .capture_stop,
    .in(disc_out), .in_valid(disc_valid),
    .capturing,
    .out_word, .out_valid, .out_last, .out_ready
  );

endmodule

`default_nettype wire

// ==== tb/receive_top_asserts.sv ====
// concurrent checks on the readout stream and the reset state
`default_nettype none

module receive_top_asserts (
  input logic                       clk,
  input logic                       reset,
  input logic                       capturing,
  input receive_pkg::readout_word_t out_word,
  input logic                       out_valid,
  input logic                       out_last,
  input logic                       out_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions
  int unsigned failures = 0;

  // a stalled word stays on the bus
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_word) && $stable(out_last))
    else begin
      failures++;
      $error("readout word changed while out_ready was low");
    end

  assert property (@(posedge clk) disable iff (reset) capturing |-> !out_valid)
    else begin
      failures++;
      $error("out_valid high during capture");
    end

  assert property (@(posedge clk) reset |=> !out_valid && !out_last && !capturing)
    else begin
      failures++;
      $error("outputs not low after reset");
    end

endmodule

bind receive_top receive_top_asserts asserts (
  .clk, .reset, .capturing, .out_word, .out_valid, .out_last, .out_ready
);

`default_nettype wire

// ==== tb/receive_top_tb.sv ====
// testbench for the capture path
// clock, reset, reference model of conditioner, discriminator and buffer, directed tests
`default_nettype none

module receive_top_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import receive_pkg::*;

  localparam int CHANNELS = 2;
  localparam int PARALLEL_SAMPLES = 2;
  localparam int SAMPLE_WIDTH = 16;
  localparam int BUFFER_DEPTH = 16;
  localparam int TIMEOUT_CYCLES = 2000;

  logic clk;
  logic reset;
  adc_word_t [CHANNELS-1:0] adc_data;
  logic [CHANNELS-1:0] adc_valid;
  receive_config_t config_data;
  logic config_load, capture_start, capture_stop, out_ready;
  readout_word_t out_word;
  logic out_valid, out_last;

  // reference model state
  receive_config_t cfg;
  sample_t last_sample [CHANNELS];
  bit active [CHANNELS];
  bit cut [CHANNELS];
  int word_index [CHANNELS];
  logic [31:0] ts_q [CHANNELS][$];
  logic [31:0] samp_q [CHANNELS][$];
  readout_word_t exp_q [$];
  // sample words seen on the readout, per channel
  int read_samples [CHANNELS];

  receive_top #(
    .CHANNELS(CHANNELS), .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
    .SAMPLE_WIDTH(SAMPLE_WIDTH), .BUFFER_DEPTH(BUFFER_DEPTH)
  ) uut (
    .clk, .reset, .adc_data, .adc_valid, .config_data, .config_load,
    .capture_start, .capture_stop, .out_word, .out_valid, .out_last, .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_error(string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_value(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, actual, expected);
      stop_with_error("value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  task automatic model_word(int c, adc_word_t w);
    adc_word_t cw;
    sample_t prev, cur, s;
    bit any_above, all_below, was_active, run_start;
    prev = last_sample[c];
    any_above = 1'b0;
    all_below = 1'b1;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      cur = w[i];
      // floor of half the step from the sample before
      cw[i] = cfg[c].differentiate ? sample_t'((int'(cur) - int'(prev)) >>> 1) : cur;
      prev = cur;
      s = cw[i];
      if (s > cfg[c].threshold_high) any_above = 1'b1;
      if (s >= cfg[c].threshold_low) all_below = 1'b0;
    end
    last_sample[c] = w[PARALLEL_SAMPLES-1];
    was_active = active[c];
    if (any_above) active[c] = 1'b1;
    else if (all_below) active[c] = 1'b0;
    if (active[c] && !cut[c]) begin
      run_start = !was_active;
      if (samp_q[c].size() == BUFFER_DEPTH || (run_start && ts_q[c].size() == BUFFER_DEPTH)) begin
        cut[c] = 1'b1;
      end else begin
        if (run_start) ts_q[c].push_back(word_index[c]);
        samp_q[c].push_back(cw);
      end
    end
    word_index[c]++;
  endtask

  function automatic readout_word_t make_word(bit is_ts, int c, logic [31:0] payload);
    return '{is_timestamp: is_ts, channel: CHANNEL_BITS'(c), payload: payload};
  endfunction

  //////////////////////////////////////////////////
  // capture sequence
  //////////////////////////////////////////////////
  task automatic set_channel(int c, int high, int low, bit diff);
    cfg[c].threshold_high = sample_t'(high);
    cfg[c].threshold_low = sample_t'(low);
    cfg[c].differentiate = diff;
  endtask

  task automatic start_capture();
    @(posedge clk);
    config_data <= cfg;
    config_load <= 1'b1;
    @(posedge clk);
    config_load <= 1'b0;
    capture_start <= 1'b1;
    @(posedge clk);
    capture_start <= 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      active[c] = 1'b0;
      cut[c] = 1'b0;
      word_index[c] = 0;
      ts_q[c] = {};
      samp_q[c] = {};
    end
  endtask

  // each channel gets count words, valid strobes are random per channel
  task automatic send_words(int count, int valid_pct, int lo, int hi);
    int sent [CHANNELS];
    int cycles;
    bit busy;
    adc_word_t w;
    foreach (sent[c]) sent[c] = 0;
    cycles = 0;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int c = 0; c < CHANNELS; c++) begin
        if (sent[c] < count && $urandom_range(99) < valid_pct) begin
          for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
            w[i] = sample_t'(lo + int'($urandom_range(hi - lo)));
          end
          adc_data[c] <= w;
          adc_valid[c] <= 1'b1;
          model_word(c, w);
          sent[c]++;
        end else begin
          adc_valid[c] <= 1'b0;
        end
        if (sent[c] < count) busy = 1'b1;
      end
      cycles++;
      if (cycles > TIMEOUT_CYCLES) stop_with_error("timeout while sending input words");
    end
    @(posedge clk);
    adc_valid <= '0;
  endtask

  task automatic collect_readout(int ready_pct);
    int n;
    int cycles;
    bit done;
    exp_q = {};
    for (int c = 0; c < CHANNELS; c++) begin
      for (int k = 0; k < ts_q[c].size(); k++) begin
        exp_q.push_back(make_word(1'b1, c, ts_q[c][k]));
      end
      for (int k = 0; k < samp_q[c].size(); k++) begin
        exp_q.push_back(make_word(1'b0, c, samp_q[c][k]));
      end
    end
    // empty capture ends with a lone terminator
    if (exp_q.size() == 0) exp_q.push_back(make_word(1'b1, CHANNELS - 1, '0));
    foreach (read_samples[c]) read_samples[c] = 0;
    n = 0;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (n >= exp_q.size()) stop_with_error("more readout words than expected");
        compare_value("out_word", out_word, exp_q[n]);
        compare_value("out_last", out_last, n == exp_q.size() - 1);
        if (!out_word.is_timestamp) read_samples[out_word.channel]++;
        done = out_last;
        n++;
      end
      @(posedge clk);
      out_ready <= done ? 1'b0 : ($urandom_range(99) < ready_pct);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) stop_with_error("timeout waiting for out_last");
    end
  endtask

  task automatic run_capture(int count, int valid_pct, int lo, int hi, int ready_pct);
    start_capture();
    send_words(count, valid_pct, lo, hi);
    repeat (2) @(posedge clk);
    capture_stop <= 1'b1;
    @(posedge clk);
    capture_stop <= 1'b0;
    collect_readout(ready_pct);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_all_saved();
    set_channel(0, -2000, -3000, 1'b0);
    set_channel(1, -2000, -3000, 1'b0);
    run_capture(12, 100, -1000, 1000, 100);
  endtask

  task automatic test_hysteresis();
    // wide band on channel 0, narrow band on channel 1
    set_channel(0, 400, -400, 1'b0);
    set_channel(1, 50, 30, 1'b0);
    run_capture(14, 60, -600, 600, 100);
  endtask

  task automatic test_nothing_saved();
    set_channel(0, 0, -100, 1'b0);
    set_channel(1, 0, -100, 1'b0);
    run_capture(8, 100, -1000, -500, 100);
  endtask

  task automatic test_differentiate();
    set_channel(0, -25000, -30000, 1'b1);
    set_channel(1, -25000, -30000, 1'b0);
    run_capture(12, 80, -20000, 20000, 100);
  endtask

  task automatic test_overflow();
    set_channel(0, -2000, -3000, 1'b0);
    set_channel(1, -2000, -3000, 1'b0);
    run_capture(40, 100, -1000, 1000, 100);
    compare_value("ch0 kept words", read_samples[0], BUFFER_DEPTH);
    compare_value("ch1 kept words", read_samples[1], BUFFER_DEPTH);
  endtask

  task automatic test_backpressure();
    set_channel(0, 400, -400, 1'b0);
    set_channel(1, 50, 30, 1'b0);
    run_capture(14, 70, -600, 600, 50);
  endtask

  initial begin
    void'($urandom(32'hc87d));
    reset = 1'b1;
    adc_data = '0;
    adc_valid = '0;
    config_data = '0;
    config_load = 1'b0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    out_ready = 1'b0;
    cfg = '0;
    foreach (last_sample[c]) last_sample[c] = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    test_all_saved();
    test_hysteresis();
    test_nothing_saved();
    test_differentiate();
    test_overflow();
    test_backpressure();
    if (uut.asserts.failures != 0) begin
      stop_with_error("assertion failures were reported");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/receive_pkg.sv
design/sample_fifo.sv
design/sample_conditioner.sv
design/sample_discriminator.sv
design/sparse_buffer.sv
design/receive_top.sv
tb/receive_top_asserts.sv
tb/receive_top_tb.sv
